// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_adr_t;

   localparam int NUM_REGS = 8;

   // instruction field positions.
   localparam int CLASS_LSB  = 14;
   localparam int RA_LSB     = 11;
   localparam int RB_LSB     = 8;
   localparam int IMM_OP_LSB = 11;
   localparam int OP_LSB     = 4;
   localparam int DISP_W     = 8;
   localparam int SHAMT_W    = 4;

   typedef enum logic [1:0] {
      LOAD  = 2'd0,
      STORE = 2'd1,
      IMM   = 2'd2,
      ARITH = 2'd3
   } inst_class_e;

   // 7 and 14 are reserved.
   typedef enum logic [3:0] {
      ADD = 4'd0,  SUB = 4'd1,  AND = 4'd2,  OR  = 4'd3,
      XOR = 4'd4,  CMP = 4'd5,  MOV = 4'd6,
      SLL = 4'd8,  SLR = 4'd9,  SRL = 4'd10, SRA = 4'd11,
      IN  = 4'd12, OUT = 4'd13, HLT = 4'd15
   } alu_op_e;

   // 4 to 7 are branches.
   typedef enum logic [2:0] {
      LI   = 3'd0,
      ADDI = 3'd1,
      SUBI = 3'd2,
      CMPI = 3'd3
   } imm_op_e;

endpackage

// File: verilog/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

   typedef enum logic [0:0] {
      SRCA_REG,   // register port 2.
      SRCA_ZERO
   } src_a_sel_e;

   typedef enum logic [1:0] {
      SRCB_REG,   // register port 1.
      SRCB_IMM,   // extended displacement.
      SRCB_SHAMT
   } src_b_sel_e;

   typedef enum logic [1:0] {
      FWD_NONE = 2'd0,
      FWD_MEM  = 2'd1,   // result leaving the memory stage.
      FWD_WB   = 2'd2    // write-back value.
   } fwd_sel_e;

   typedef enum logic [0:0] {
      WB_ALU,
      WB_MEM
   } wb_sel_e;

endpackage

// File: verilog/controller.sv
`timescale 1ns/1ns

module controller import cpu_isa_pkg::*, pipe_ctrl_pkg::*; (
   input  word_t      inst_id,
   output alu_op_e    alu_op,
   output src_a_sel_e src_a_sel,
   output src_b_sel_e src_b_sel,
   output logic       mem_read,
   output logic       mem_write,
   output logic       regwrite,
   output logic       use_ra,
   output logic       use_rb,
   output logic       out_en,
   output logic       halt,
   output logic       is_load,
   output logic       dest_is_ra,
   output wb_sel_e    wb_sel
);

   inst_class_e cls;
   alu_op_e     op;
   imm_op_e     imm_op;

   assign cls    = inst_class_e'(inst_id[CLASS_LSB +: $bits(inst_class_e)]);
   assign op     = alu_op_e'(inst_id[OP_LSB +: $bits(alu_op_e)]);
   assign imm_op = imm_op_e'(inst_id[IMM_OP_LSB +: $bits(imm_op_e)]);

   always_comb begin
      alu_op     = ADD;   // no-operation defaults.
      src_a_sel  = SRCA_REG;
      src_b_sel  = SRCB_REG;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      regwrite   = 1'b0;
      use_ra     = 1'b0;
      use_rb     = 1'b0;
      out_en     = 1'b0;
      halt       = 1'b0;
      is_load    = 1'b0;
      dest_is_ra = 1'b0;
      wb_sel     = WB_ALU;
      case (cls)
         LOAD: begin
            src_b_sel  = SRCB_IMM;
            mem_read   = 1'b1;
            regwrite   = 1'b1;
            use_rb     = 1'b1;
            is_load    = 1'b1;
            dest_is_ra = 1'b1;
            wb_sel     = WB_MEM;
         end
         STORE: begin
            src_b_sel = SRCB_IMM;
            mem_write = 1'b1;
            use_ra    = 1'b1;
            use_rb    = 1'b1;
         end
         IMM: begin
            src_b_sel = SRCB_IMM;
            case (imm_op)
               LI: begin
                  src_a_sel = SRCA_ZERO;
                  regwrite  = 1'b1;
               end
               ADDI, SUBI: begin
                  alu_op   = (imm_op == SUBI) ? SUB : ADD;
                  regwrite = 1'b1;
                  use_rb   = 1'b1;
               end
               CMPI: begin
                  alu_op = CMP;
                  use_rb = 1'b1;
               end
               default: src_b_sel = SRCB_REG;   // branch.
            endcase
         end
         ARITH: begin
            case (op)
               ADD, SUB, AND, OR, XOR, CMP: begin
                  alu_op   = op;
                  regwrite = (op != CMP);
                  use_ra   = 1'b1;
                  use_rb   = 1'b1;
               end
               MOV, IN: begin
                  alu_op   = op;
                  regwrite = 1'b1;
                  use_ra   = (op == MOV);
               end
               SLL, SLR, SRL, SRA: begin
                  alu_op    = op;
                  src_b_sel = SRCB_SHAMT;
                  regwrite  = 1'b1;
                  use_rb    = 1'b1;
               end
               OUT: begin
                  alu_op = op;
                  use_ra = 1'b1;
                  out_en = 1'b1;
               end
               HLT: begin
                  alu_op = op;
                  halt   = 1'b1;
               end
               default: alu_op = ADD;   // reserved.
            endcase
         end
         default: alu_op = ADD;
      endcase
   end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ns

module regfile import cpu_isa_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     regwrite,
   input  reg_adr_t ra_adr,
   input  reg_adr_t rb_adr,
   input  reg_adr_t regwrite_adr,
   input  word_t    regwrite_dat,
   output word_t    rd1,
   output word_t    rd2
);

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (regwrite) begin
         regs[regwrite_adr] <= regwrite_dat;
      end
   end

   // write-first bypass on both ports.
   assign rd1 = (regwrite && regwrite_adr == ra_adr) ? regwrite_dat : regs[ra_adr];
   assign rd2 = (regwrite && regwrite_adr == rb_adr) ? regwrite_dat : regs[rb_adr];

endmodule

// File: verilog/reg_scoreboard.sv
`timescale 1ns/1ns

module reg_scoreboard import cpu_isa_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       issue,
   input  logic       issue_is_load,
   input  reg_adr_t   issue_adr,
   output logic [1:0] age_ra,
   output logic [1:0] age_rb,
   output logic       load_ra,
   output logic       load_rb,
   input  reg_adr_t   ra_adr,
   input  reg_adr_t   rb_adr
);

   logic [1:0] age  [NUM_REGS];   // stages since the newest writer issued.
   logic       load [NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            age[i]  <= 2'd0;
            load[i] <= 1'b0;
         end
      end else begin
         for (int i = 0; i < NUM_REGS; i++) begin
            if (issue && issue_adr == reg_adr_t'(i)) begin
               age[i]  <= 2'd1;
               load[i] <= issue_is_load;
            end else if (age[i] != 2'd0) begin
               age[i] <= age[i] + 2'd1;   // 3 wraps to 0.
               if (age[i] == 2'd3) begin
                  load[i] <= 1'b0;
               end
            end
         end
      end
   end

   assign age_ra  = age[ra_adr];
   assign age_rb  = age[rb_adr];
   assign load_ra = load[ra_adr];
   assign load_rb = load[rb_adr];

endmodule

// File: verilog/operand_hazard.sv
`timescale 1ns/1ns

module operand_hazard import pipe_ctrl_pkg::*; (
   input  logic       use_ra,
   input  logic       use_rb,
   input  logic       load_ra,
   input  logic       load_rb,
   input  logic       flushed,
   input  logic [1:0] age_ra,
   input  logic [1:0] age_rb,
   output fwd_sel_e   fwd_a,
   output fwd_sel_e   fwd_b,
   output logic       stall
);

   logic hold_ra;
   logic hold_rb;

   function automatic fwd_sel_e age_to_fwd(input logic used, input logic [1:0] age);
      fwd_sel_e sel;
      sel = FWD_NONE;
      if (used) begin
         case (age)
            2'd1:    sel = FWD_MEM;
            2'd2:    sel = FWD_WB;
            default: sel = FWD_NONE;   // age 3 reads through the bypass.
         endcase
      end
      return sel;
   endfunction

   // ====================
   // forwarding selects
   // ====================
   assign fwd_a = age_to_fwd(use_rb, age_rb);   // A reads rb.
   assign fwd_b = age_to_fwd(use_ra, age_ra);   // B reads ra.

   // ====================
   // load-use stall
   // ====================
   // loaded data is not ready until write-back.
   assign hold_ra = use_ra && load_ra && (age_ra == 2'd1);
   assign hold_rb = use_rb && load_rb && (age_rb == 2'd1);

   assign stall = (hold_ra || hold_rb) && !flushed;   // a flush drops the reader.

endmodule

// File: verilog/decode.sv
`timescale 1ns/1ns

module decode import cpu_isa_pkg::*, pipe_ctrl_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               flushed,
   input  logic               regwrite,
   input  word_t              inst_id,
   input  reg_adr_t           regwrite_adr,
   input  word_t              regwrite_dat,
   output word_t              rd1_id,
   output word_t              rd2_id,
   output word_t              imm_id,
   output logic [SHAMT_W-1:0] shamt_id,
   output alu_op_e            alu_op_id,
   output src_a_sel_e         src_a_sel_id,
   output src_b_sel_e         src_b_sel_id,
   output logic               mem_read_id,
   output logic               mem_write_id,
   output wb_sel_e            wb_sel_id,
   output logic               regwrite_id,
   output logic               out_en_id,
   output logic               halt_id,
   output fwd_sel_e           fwd_a_id,
   output fwd_sel_e           fwd_b_id,
   output reg_adr_t           regwrite_adr_id,
   output logic               stall
);

   reg_adr_t   ra_adr;
   reg_adr_t   rb_adr;
   logic       use_ra, use_rb;
   logic       is_load, dest_is_ra;
   logic       issue;
   logic [1:0] age_ra, age_rb;
   logic       load_ra, load_rb;

   assign ra_adr   = inst_id[RA_LSB +: $bits(reg_adr_t)];
   assign rb_adr   = inst_id[RB_LSB +: $bits(reg_adr_t)];
   assign shamt_id = inst_id[SHAMT_W-1:0];
   assign imm_id   = {{($bits(word_t) - DISP_W){inst_id[DISP_W-1]}}, inst_id[DISP_W-1:0]};

   assign regwrite_adr_id = dest_is_ra ? ra_adr : rb_adr;   // only LOAD writes ra.
   assign issue           = regwrite_id && !stall && !flushed;

   controller u_ctrl (
      .inst_id    (inst_id),
      .alu_op     (alu_op_id),
      .src_a_sel  (src_a_sel_id),
      .src_b_sel  (src_b_sel_id),
      .mem_read   (mem_read_id),
      .mem_write  (mem_write_id),
      .regwrite   (regwrite_id),
      .use_ra     (use_ra),
      .use_rb     (use_rb),
      .out_en     (out_en_id),
      .halt       (halt_id),
      .is_load    (is_load),
      .dest_is_ra (dest_is_ra),
      .wb_sel     (wb_sel_id)
   );

   regfile u_regfile ( .rd1(rd1_id), .rd2(rd2_id), .* );

   reg_scoreboard u_scoreboard ( .issue_is_load(is_load), .issue_adr(regwrite_adr_id), .* );

   operand_hazard u_hazard ( .fwd_a(fwd_a_id), .fwd_b(fwd_b_id), .* );

endmodule

// File: verilog/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg import cpu_isa_pkg::*, pipe_ctrl_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic                bubble,
   input  word_t               rd1_id, rd2_id, imm_id,
   input  logic [SHAMT_W-1:0]  shamt_id,
   input  alu_op_e             alu_op_id,
   input  src_a_sel_e          src_a_sel_id,
   input  src_b_sel_e          src_b_sel_id,
   input  fwd_sel_e            fwd_a_id, fwd_b_id,
   input  logic                mem_read_id, mem_write_id,
   input  wb_sel_e             wb_sel_id,
   input  logic                regwrite_id,
   input  reg_adr_t            regwrite_adr_id,
   input  logic                out_en_id, halt_id,
   output word_t               rd1_ex, rd2_ex, imm_ex,
   output logic [SHAMT_W-1:0]  shamt_ex,
   output alu_op_e             alu_op_ex,
   output src_a_sel_e          src_a_sel_ex,
   output src_b_sel_e          src_b_sel_ex,
   output fwd_sel_e            fwd_a_ex, fwd_b_ex,
   output logic                mem_read_ex, mem_write_ex,
   output wb_sel_e             wb_sel_ex,
   output logic                regwrite_ex,
   output reg_adr_t            regwrite_adr_ex,
   output logic                out_en_ex, halt_ex
);

   // ====================
   // control fields
   // ====================
   always_ff @(posedge clk) begin
      if (reset || bubble) begin
         regwrite_ex  <= 1'b0;
         mem_read_ex  <= 1'b0;
         mem_write_ex <= 1'b0;
         out_en_ex    <= 1'b0;
         halt_ex      <= 1'b0;
         fwd_a_ex     <= FWD_NONE;
         fwd_b_ex     <= FWD_NONE;
      end else begin
         regwrite_ex  <= regwrite_id;
         mem_read_ex  <= mem_read_id;
         mem_write_ex <= mem_write_id;
         out_en_ex    <= out_en_id;
         halt_ex      <= halt_id;
         fwd_a_ex     <= fwd_a_id;
         fwd_b_ex     <= fwd_b_id;
      end
   end

   // ====================
   // operands and payload
   // ====================
   always_ff @(posedge clk) begin
      rd1_ex          <= rd1_id;
      rd2_ex          <= rd2_id;
      imm_ex          <= imm_id;
      shamt_ex        <= shamt_id;
      alu_op_ex       <= alu_op_id;
      src_a_sel_ex    <= src_a_sel_id;
      src_b_sel_ex    <= src_b_sel_id;
      wb_sel_ex       <= wb_sel_id;
      regwrite_adr_ex <= regwrite_adr_id;
   end

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/1ns

module id_stage import cpu_isa_pkg::*, pipe_ctrl_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  word_t               inst_id,
   input  logic                flushed,
   input  logic                regwrite,
   input  reg_adr_t            regwrite_adr,
   input  word_t               regwrite_dat,
   output word_t               rd1_ex, rd2_ex, imm_ex,
   output logic [SHAMT_W-1:0]  shamt_ex,
   output alu_op_e             alu_op_ex,
   output src_a_sel_e          src_a_sel_ex,
   output src_b_sel_e          src_b_sel_ex,
   output fwd_sel_e            fwd_a_ex, fwd_b_ex,
   output logic                mem_read_ex, mem_write_ex,
   output wb_sel_e             wb_sel_ex,
   output logic                regwrite_ex,
   output reg_adr_t            regwrite_adr_ex,
   output logic                out_en_ex, halt_ex,
   output logic                en_pc,
   output logic                en_ifid
);

   word_t              rd1_id, rd2_id, imm_id;
   logic [SHAMT_W-1:0] shamt_id;
   alu_op_e            alu_op_id;
   src_a_sel_e         src_a_sel_id;
   src_b_sel_e         src_b_sel_id;
   fwd_sel_e           fwd_a_id, fwd_b_id;
   logic               mem_read_id, mem_write_id;
   wb_sel_e            wb_sel_id;
   logic               regwrite_id;
   reg_adr_t           regwrite_adr_id;
   logic               out_en_id, halt_id;
   logic               stall;
   logic               bubble;

   decode u_decode ( .* );

   assign bubble = stall || flushed;   // killed or held instruction.

   id_ex_reg u_id_ex ( .* );

   // fetch holds while the load result is on its way.
   assign en_pc   = !stall;
   assign en_ifid = !stall;

endmodule

// File: tests/id_stage_properties.sv
`timescale 1ns/1ns

module id_stage_properties (
   input logic clk,
   input logic reset,
   input logic en_pc,
   input logic en_ifid,
   input logic regwrite_ex,
   input logic mem_read_ex,
   input logic mem_write_ex
);

   en_pair_equal: assert property (@(posedge clk) disable iff (reset) en_pc == en_ifid)
      else $error("en_pc and en_ifid differ");

   // a held instruction leaves a bubble behind it.
   stall_gives_bubble: assert property (@(posedge clk) disable iff (reset)
      !en_pc |=> !regwrite_ex && !mem_read_ex && !mem_write_ex)
      else $error("stall did not insert a bubble into ID/EX");

   stall_one_cycle: assert property (@(posedge clk) disable iff (reset) !en_pc |=> en_pc)
      else $error("stall lasted two cycles in a row");

   reset_clears_write: assert property (@(posedge clk) reset |=> !regwrite_ex)
      else $error("regwrite_ex high in the cycle after reset");

endmodule

bind id_stage id_stage_properties u_props (
   .clk          (clk),
   .reset        (reset),
   .en_pc        (en_pc),
   .en_ifid      (en_ifid),
   .regwrite_ex  (regwrite_ex),
   .mem_read_ex  (mem_read_ex),
   .mem_write_ex (mem_write_ex)
);

// File: tests/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage import cpu_isa_pkg::*, pipe_ctrl_pkg::*; ();

   typedef struct packed {
      alu_op_e    alu_op;
      src_a_sel_e src_a;
      src_b_sel_e src_b;
      wb_sel_e    wb_sel;
      logic       mem_read, mem_write, regwrite, use_ra, use_rb;
      logic       out_en, halt, is_load, dest_is_ra;
   } dec_t;

   logic               clk = 1'b0;
   logic               reset, flushed, regwrite;
   word_t              inst_id, regwrite_dat;
   reg_adr_t           regwrite_adr;
   word_t              rd1_ex, rd2_ex, imm_ex;
   logic [SHAMT_W-1:0] shamt_ex;
   alu_op_e            alu_op_ex;
   src_a_sel_e         src_a_sel_ex;
   src_b_sel_e         src_b_sel_ex;
   fwd_sel_e           fwd_a_ex, fwd_b_ex;
   logic               mem_read_ex, mem_write_ex, regwrite_ex, out_en_ex, halt_ex;
   wb_sel_e            wb_sel_ex;
   reg_adr_t           regwrite_adr_ex;
   logic               en_pc, en_ifid;

   // ====================
   // reference model state
   // ====================
   word_t       regs_m [8];
   logic [1:0]  age_m  [8];
   logic        load_m [8];
   dec_t        exp_dec;
   logic        exp_bubble, cur_stall;
   fwd_sel_e    exp_fwd_a, exp_fwd_b;
   word_t       exp_rd1, exp_rd2, exp_imm;
   logic [3:0]  exp_shamt;
   reg_adr_t    exp_adr;
   logic [31:0] lfsr = 32'h865e;
   int          checks, errors;

   id_stage dut ( .* );

   always #10 clk = ~clk;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic dec_t decode_ref(input word_t inst);
      dec_t       d;
      logic [3:0] op;
      logic [2:0] iop;
      d   = '0;   // no-operation.
      op  = inst[7:4];
      iop = inst[13:11];
      case (inst[15:14])
         2'd0: begin
            d.src_b  = SRCB_IMM;
            d.wb_sel = WB_MEM;
            {d.mem_read, d.regwrite, d.use_rb, d.is_load, d.dest_is_ra} = '1;
         end
         2'd1: begin
            d.src_b = SRCB_IMM;
            {d.mem_write, d.use_ra, d.use_rb} = '1;
         end
         2'd2: begin
            if (iop <= 3'd3) begin   // 4 and up are branches.
               d.src_b    = SRCB_IMM;
               d.src_a    = (iop == 3'd0) ? SRCA_ZERO : SRCA_REG;
               d.alu_op   = (iop == 3'd2) ? SUB : (iop == 3'd3) ? CMP : ADD;
               d.regwrite = (iop != 3'd3);
               d.use_rb   = (iop != 3'd0);
            end
         end
         default: begin
            if (op <= 4'd5) begin
               {d.use_ra, d.use_rb} = '1;
               d.regwrite = (op != 4'd5);
            end else if (op == 4'd6 || op == 4'd12) begin   // mov and in.
               d.regwrite = 1'b1;
               d.use_ra   = (op == 4'd6);
            end else if (op >= 4'd8 && op <= 4'd11) begin
               d.src_b    = SRCB_SHAMT;
               d.regwrite = 1'b1;
               d.use_rb   = 1'b1;
            end else if (op == 4'd13) begin
               {d.use_ra, d.out_en} = '1;
            end else if (op == 4'd15) begin
               d.halt = 1'b1;
            end
            if (op != 4'd7 && op != 4'd14) begin
               d.alu_op = alu_op_e'(op);
            end
         end
      endcase
      return d;
   endfunction

   function automatic fwd_sel_e fwd_ref(input logic used, input logic [1:0] age);
      if (!used || age == 2'd0 || age == 2'd3) begin
         return FWD_NONE;
      end
      return (age == 2'd1) ? FWD_MEM : FWD_WB;
   endfunction

   function automatic word_t mk_arith(input alu_op_e op, input reg_adr_t ra, input reg_adr_t rb);
      return {ARITH, ra, rb, op, 4'h3};
   endfunction

   function automatic word_t mk_load(input reg_adr_t ra, input reg_adr_t rb, input logic [7:0] disp);
      return {LOAD, ra, rb, disp};
   endfunction

   function automatic word_t mk_imm(input imm_op_e iop, input reg_adr_t rb, input logic [7:0] disp);
      return {IMM, iop, rb, disp};
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_fwd(input string name, input fwd_sel_e got, input fwd_sel_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_src_b(input string name, input src_b_sel_e got, input src_b_sel_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic drive_wb();
      regwrite     <= (rand_bits(1) != 0);
      regwrite_adr <= reg_adr_t'(rand_bits(3));
      regwrite_dat <= word_t'(rand_bits(16));
   endtask

   // called on a rising edge; returns on the edge that takes the instruction.
   task automatic send_inst(input word_t inst, input logic fl);
      int n;
      inst_id <= inst;
      flushed <= fl;
      drive_wb();
      @(posedge clk);
      n = 0;
      while (cur_stall) begin   // IF/ID holds the instruction.
         if (n == 2) begin
            abort_run("stall did not clear within two cycles");
         end
         n++;
         flushed <= 1'b0;
         drive_wb();
         @(posedge clk);
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while ((en_pc !== 1'b1 || regwrite_ex !== 1'b0 || fwd_a_ex !== FWD_NONE) && n < 8);
      if (en_pc !== 1'b1 || regwrite_ex !== 1'b0 || fwd_a_ex !== FWD_NONE) begin
         abort_run("outputs did not settle to a bubble after reset");
      end
   endtask

   task automatic wait_for_stall();
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (en_pc !== 1'b0 && n < 4);
      if (en_pc !== 1'b0) begin
         abort_run("load followed by a user of its result did not stall fetch");
      end
   endtask

   // ====================
   // compare and predict
   // ====================
   initial begin : compare_and_predict
      dec_t     d;
      reg_adr_t ra;
      reg_adr_t rb;
      logic     issue;
      @(posedge clk);
      forever begin
         @(negedge clk);
         check_bit("regwrite_ex", regwrite_ex, exp_dec.regwrite && !exp_bubble);
         check_bit("mem_read_ex", mem_read_ex, exp_dec.mem_read && !exp_bubble);
         check_bit("mem_write_ex", mem_write_ex, exp_dec.mem_write && !exp_bubble);
         check_bit("out_en_ex", out_en_ex, exp_dec.out_en && !exp_bubble);
         check_bit("halt_ex", halt_ex, exp_dec.halt && !exp_bubble);
         check_fwd("fwd_a_ex", fwd_a_ex, exp_bubble ? FWD_NONE : exp_fwd_a);
         check_fwd("fwd_b_ex", fwd_b_ex, exp_bubble ? FWD_NONE : exp_fwd_b);
         if (!exp_bubble) begin
            check_alu_op("alu_op_ex", alu_op_ex, exp_dec.alu_op);
            check_bit("src_a_sel_ex", src_a_sel_ex, exp_dec.src_a);
            check_src_b("src_b_sel_ex", src_b_sel_ex, exp_dec.src_b);
            check_bit("wb_sel_ex", wb_sel_ex, exp_dec.wb_sel);
            check_word("regwrite_adr_ex", word_t'(regwrite_adr_ex), word_t'(exp_adr));
            check_word("rd1_ex", rd1_ex, exp_rd1);
            check_word("rd2_ex", rd2_ex, exp_rd2);
            check_word("imm_ex", imm_ex, exp_imm);
            check_word("shamt_ex", word_t'(shamt_ex), word_t'(exp_shamt));
         end
         // the cycle now in decode.
         d  = decode_ref(inst_id);
         ra = inst_id[13:11];
         rb = inst_id[10:8];
         cur_stall = ((d.use_ra && load_m[ra] && age_m[ra] == 2'd1) ||
                      (d.use_rb && load_m[rb] && age_m[rb] == 2'd1)) && !flushed;
         check_bit("en_pc", en_pc, !cur_stall);
         check_bit("en_ifid", en_ifid, !cur_stall);
         exp_dec    = d;
         exp_bubble = reset || cur_stall || flushed;
         exp_fwd_a  = fwd_ref(d.use_rb, age_m[rb]);   // A reads rb.
         exp_fwd_b  = fwd_ref(d.use_ra, age_m[ra]);
         exp_rd1    = (regwrite && regwrite_adr == ra) ? regwrite_dat : regs_m[ra];
         exp_rd2    = (regwrite && regwrite_adr == rb) ? regwrite_dat : regs_m[rb];
         exp_imm    = {{8{inst_id[7]}}, inst_id[7:0]};
         exp_shamt  = inst_id[3:0];
         exp_adr    = d.dest_is_ra ? ra : rb;
         if (reset) begin
            for (int i = 0; i < 8; i++) begin
               regs_m[i] = '0;
               age_m[i]  = 2'd0;
               load_m[i] = 1'b0;
            end
         end else begin
            if (regwrite) begin
               regs_m[regwrite_adr] = regwrite_dat;
            end
            issue = d.regwrite && !cur_stall && !flushed;
            for (int i = 0; i < 8; i++) begin
               if (issue && exp_adr == i) begin
                  age_m[i]  = 2'd1;
                  load_m[i] = d.is_load;
               end else if (age_m[i] != 2'd0) begin
                  load_m[i] = load_m[i] && age_m[i] != 2'd3;
                  age_m[i]  = age_m[i] + 2'd1;   // 3 wraps to 0.
               end
            end
         end
      end
   end

   initial begin : stimulus
      reset        = 1'b1;
      inst_id      = '0;
      flushed      = 1'b0;
      regwrite     = 1'b0;
      regwrite_adr = '0;
      regwrite_dat = '0;
      exp_dec      = '0;
      exp_bubble   = 1'b1;
      cur_stall    = 1'b0;
      checks       = 0;
      errors       = 0;
      for (int i = 0; i < 8; i++) begin
         regs_m[i] = '0;
         age_m[i]  = 2'd0;
         load_m[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      wait_reset_release();
      @(posedge clk);

      // writer then readers at distance one, two and three.
      send_inst(mk_imm(LI, 3'd1, 8'h25), 1'b0);
      send_inst(mk_arith(ADD, 3'd1, 3'd2), 1'b0);
      send_inst(mk_arith(SUB, 3'd1, 3'd3), 1'b0);
      send_inst(mk_arith(XOR, 3'd1, 3'd4), 1'b0);
      send_inst(mk_imm(ADDI, 3'd4, 8'hf0), 1'b0);
      send_inst(mk_arith(MOV, 3'd1, 3'd4), 1'b0);   // rb unused.

      // load-use.
      send_inst(mk_load(3'd5, 3'd0, 8'h10), 1'b0);
      inst_id <= mk_arith(ADD, 3'd5, 3'd6);
      flushed <= 1'b0;
      drive_wb();
      wait_for_stall();
      @(posedge clk);
      @(posedge clk);   // held instruction leaves with FWD_WB.

      // flush cancels the stall and the writer.
      send_inst(mk_load(3'd6, 3'd0, 8'h20), 1'b0);
      send_inst(mk_arith(ADD, 3'd6, 3'd7), 1'b1);
      send_inst(mk_imm(LI, 3'd7, 8'h55), 1'b1);
      send_inst(mk_arith(MOV, 3'd7, 3'd1), 1'b0);

      repeat (3000) begin
         send_inst(word_t'(rand_bits(16)), rand_bits(4) == 0);
      end
      @(negedge clk);
      #1;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: flist.f
verilog/cpu_isa_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/controller.sv
verilog/regfile.sv
verilog/reg_scoreboard.sv
verilog/operand_hazard.sv
verilog/decode.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
tests/id_stage_properties.sv
tests/tb_id_stage.sv
